// ==== uopSequencer_defines.svh ====
`ifndef UOPSEQUENCER_DEFINES_SVH
`define UOPSEQUENCER_DEFINES_SVH

`define INSTR_W 32 // ARM instruction word
`define NUM_REGS 16 // Architectural registers, also register-list width
`define REG_W 4 // Register number
`define RZ_CODE 4'b1111 // Register code that selects scratch Rz
`define WORD_SHIFT 2 // Register count to byte offset
`define OFFSET_W 12 // Immediate offset of a single transfer

`define COND_HI 31 // Condition field
`define COND_LO 28
`define LINK_BIT 24 // L bit of B/BL
`define P_BIT 24 // Pre/post indexing
`define U_BIT 23 // Up/down
`define W_BIT 21 // Base writeback
`define L_BIT 20 // Load/store
`define RN_HI 19 // Base register field
`define RN_LO 16
`define OP2_HI 11 // Shifter operand field

`endif

// ==== uopPkg.sv ====
`include "uopSequencer_defines.svh"

package uopPkg;

	// Sequencer states, one per micro-op slot
	typedef enum logic [2:0] {
		ready, // Idle or first micro-op
		rsrSecond, // Original op on Rz
		blSecond, // Plain branch
		ldm, // Later load transfers
		stm, // Later store transfers
		listWriteback // Base update after the list
	} seqStateT;

	// What the instruction in decode needs
	typedef enum logic [2:0] {
		passKind,
		rsrKind,
		blKind,
		ldmKind,
		stmKind
	} seqKindT;

	typedef logic [`NUM_REGS-1:0] regListT; // One bit per register
	typedef logic [`REG_W-1:0] regNumT;
	typedef logic [$clog2(`NUM_REGS + 1)-1:0] regCountT; // 0 to 16 registers
	typedef logic [`OFFSET_W-1:0] offsetT;

	// Control sent to the datapath with each micro-op
	typedef struct packed {
		logic instrMux; // Micro-op replaces the instruction
		logic noFlagUpdate; // Suppress flag write
		logic uopStall; // Hold decode
		logic [3:0] rzSelect; // {RA1 mux, WA3, RA2, RA1} take Rz
		logic prevRsr; // Second RSR micro-op
		logic listForward; // Forward Rz address between transfers
	} uopCtrlT;

endpackage

// ==== uopClassifier.sv ====
`timescale 1ns/1ps
`include "uopSequencer_defines.svh"

module uopClassifier (
	input logic [`INSTR_W-1:0] instr,
	output uopPkg::seqKindT kind
);

	logic isRsr;
	logic isBxPattern;
	logic isBl;
	logic isList;
	logic listEmpty;

	// BX/BLX share the RSR bit pattern
	assign isBxPattern = (instr[27:8] == {8'b0001_0010, 12'hFFF}) && !instr[6];

	// Register form data processing with Rs shift
	assign isRsr = (instr[27:25] == 3'b000) // Data processing, register operand
		&& !instr[7] // Not multiply or extra load/store
		&& instr[4] // Shift amount from Rs
		&& !isBxPattern;

	assign isBl = (instr[27:25] == 3'b101) && instr[`LINK_BIT]; // Branch with link

	assign listEmpty = (instr[`NUM_REGS-1:0] == '0);
	assign isList = (instr[27:25] == 3'b100) && !listEmpty; // Empty list passes through

	always_comb begin
		kind = uopPkg::passKind;
		if (isRsr)
			kind = uopPkg::rsrKind;
		else if (isBl)
			kind = uopPkg::blKind;
		else if (isList) begin
			if (instr[`L_BIT])
				kind = uopPkg::ldmKind; // Load multiple
			else
				kind = uopPkg::stmKind; // Store multiple
		end
	end

endmodule

// ==== regListTracker.sv ====
`timescale 1ns/1ps
`include "uopSequencer_defines.svh"

module regListTracker (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic [`INSTR_W-1:0] instr,
	input uopPkg::seqStateT state,
	output uopPkg::regNumT nextReg,
	output uopPkg::regCountT regsLeft,
	output uopPkg::regCountT listCount,
	output uopPkg::offsetT startOffset,
	output logic addUp
);

	uopPkg::regListT instrList;
	uopPkg::regListT curList;
	uopPkg::regListT remainList; // Registers not yet transferred

	assign instrList = instr[`NUM_REGS-1:0];
	assign curList = (state == uopPkg::ready) ? instrList : remainList; // Fresh list in ready

	// Lowest set register wins
	always_comb begin
		nextReg = '0;
		for (int i = `NUM_REGS - 1; i >= 0; i--) begin
			if (curList[i])
				nextReg = uopPkg::regNumT'(i);
		end
	end

	assign regsLeft = uopPkg::regCountT'($countones(curList));
	assign listCount = uopPkg::regCountT'($countones(instrList)); // n for offsets and writeback

	// Drop the register just issued
	always_ff @(posedge clk) begin
		if (reset)
			remainList <= '0;
		else if (!stall)
			remainList <= curList & ~(uopPkg::regListT'(1) << nextReg);
	end

	// Start offset from Rn per addressing mode
	always_comb begin
		case ({instr[`P_BIT], instr[`U_BIT]})
			2'b00: begin
				startOffset = uopPkg::offsetT'(listCount - 1'b1) << `WORD_SHIFT; // DA
				addUp = 1'b0;
			end
			2'b01: begin
				startOffset = '0; // IA
				addUp = 1'b1;
			end
			2'b10: begin
				startOffset = uopPkg::offsetT'(listCount) << `WORD_SHIFT; // DB
				addUp = 1'b0;
			end
			default: begin
				startOffset = uopPkg::offsetT'(4); // IB
				addUp = 1'b1;
			end
		endcase
	end

endmodule

// ==== uopStateMachine.sv ====
`timescale 1ns/1ps
`include "uopSequencer_defines.svh"

module uopStateMachine (
	input logic clk,
	input logic reset,
	input logic stall,
	input uopPkg::seqKindT kind,
	input uopPkg::regCountT regsLeft,
	input logic [`INSTR_W-1:0] instr,
	output uopPkg::seqStateT state
);

	uopPkg::seqStateT nextState;
	logic wBit;
	logic lastReg;

	assign wBit = instr[`W_BIT]; // Base writeback requested
	assign lastReg = (regsLeft <= uopPkg::regCountT'(1)); // This transfer is the final one

	always_comb begin
		nextState = uopPkg::ready; // Single-slot states fall back here
		case (state)
			uopPkg::ready: begin
				case (kind)
					uopPkg::rsrKind: nextState = uopPkg::rsrSecond;
					uopPkg::blKind: nextState = uopPkg::blSecond;
					uopPkg::ldmKind, uopPkg::stmKind: begin
						if (!lastReg) begin
							if (kind == uopPkg::ldmKind)
								nextState = uopPkg::ldm;
							else
								nextState = uopPkg::stm;
						end else if (wBit) begin
							nextState = uopPkg::listWriteback; // One register, then base update
						end
					end
					default: nextState = uopPkg::ready; // Pass-through
				endcase
			end
			uopPkg::ldm, uopPkg::stm: begin
				if (!lastReg)
					nextState = state; // More registers to go
				else if (wBit)
					nextState = uopPkg::listWriteback;
			end
			default: nextState = uopPkg::ready;
		endcase
	end

	// Stall freezes the sequence
	always_ff @(posedge clk) begin
		if (reset)
			state <= uopPkg::ready;
		else if (!stall)
			state <= nextState;
	end

endmodule

// ==== uopEncoder.sv ====
`timescale 1ns/1ps
`include "uopSequencer_defines.svh"

module uopEncoder (
	input logic [`INSTR_W-1:0] instr,
	input uopPkg::seqStateT state,
	input uopPkg::seqKindT kind,
	input uopPkg::regNumT nextReg,
	input uopPkg::regCountT regsLeft,
	input uopPkg::regCountT listCount,
	input uopPkg::offsetT startOffset,
	input logic addUp,
	output logic [`INSTR_W-1:0] uopInstr,
	output uopPkg::uopCtrlT ctrl
);

	logic [3:0] cond;
	logic [`REG_W-1:0] rn;
	logic moreUops;
	logic wbUp;

	assign cond = instr[`COND_HI:`COND_LO]; // Every micro-op keeps the condition
	assign rn = instr[`RN_HI:`RN_LO];
	assign wbUp = instr[`U_BIT];

	// Another micro-op follows this transfer
	assign moreUops = (regsLeft > uopPkg::regCountT'(1)) || instr[`W_BIT];

	always_comb begin
		uopInstr = instr; // Pass-through by default
		ctrl = '0;
		case (state)
			uopPkg::ready: begin
				case (kind)
					uopPkg::rsrKind: begin
						// MOV Rz, Rm shift Rs
						uopInstr = {cond, 3'b000, 4'b1101, 1'b0, 4'b0000, `RZ_CODE,
							instr[`OP2_HI:0]};
						ctrl.instrMux = 1'b1;
						ctrl.noFlagUpdate = 1'b1; // Flags come from the second op
						ctrl.uopStall = 1'b1;
						ctrl.rzSelect = 4'b1100; // Write Rz
					end
					uopPkg::blKind: begin
						// SUB r14, r15, #4
						uopInstr = {cond, 3'b001, 4'b0010, 1'b0, 4'b1111, 4'b1110, 4'b0000, 8'd4};
						ctrl.instrMux = 1'b1;
						ctrl.uopStall = 1'b1;
					end
					uopPkg::ldmKind, uopPkg::stmKind: begin
						// Pre-indexed word transfer from Rn, no writeback
						uopInstr = {cond, 3'b010, 1'b1, addUp, 1'b0, 1'b0,
							kind == uopPkg::ldmKind, rn, nextReg, startOffset};
						ctrl.instrMux = 1'b1;
						ctrl.noFlagUpdate = 1'b1;
						ctrl.uopStall = moreUops;
					end
					default: ctrl = '0;
				endcase
			end
			uopPkg::rsrSecond: begin
				uopInstr = {instr[`INSTR_W-1:12], 8'b0, `RZ_CODE}; // Rz as unshifted Rm
				ctrl.instrMux = 1'b1;
				ctrl.rzSelect = 4'b0010; // Rz on read port 2
				ctrl.prevRsr = 1'b1;
			end
			uopPkg::blSecond: begin
				uopInstr = {instr[`INSTR_W-1:`LINK_BIT+1], 1'b0, instr[`LINK_BIT-1:0]};
				ctrl.instrMux = 1'b1;
			end
			uopPkg::ldm, uopPkg::stm: begin
				// Next word at Rz + 4
				uopInstr = {cond, 3'b010, 1'b1, 1'b1, 1'b0, 1'b0, state == uopPkg::ldm,
					`RZ_CODE, nextReg, uopPkg::offsetT'(4)};
				ctrl.instrMux = 1'b1;
				ctrl.noFlagUpdate = 1'b1;
				ctrl.uopStall = moreUops;
				ctrl.rzSelect = 4'b0001; // Base from Rz
				ctrl.listForward = 1'b1;
			end
			uopPkg::listWriteback: begin
				// Rn = Rn +/- n*4, immediate rotated right by 30
				uopInstr = {cond, 3'b001, 1'b0, wbUp, ~wbUp, 1'b0, 1'b0, rn, rn,
					4'b1111, 3'b000, listCount};
				ctrl.instrMux = 1'b1;
				ctrl.noFlagUpdate = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

// ==== uopSequencer.sv ====
`timescale 1ns/1ps
`include "uopSequencer_defines.svh"

module uopSequencer (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic [`INSTR_W-1:0] instr,
	output logic [`INSTR_W-1:0] uopInstr,
	output uopPkg::uopCtrlT ctrl
);

	uopPkg::seqKindT kind;
	uopPkg::seqStateT state;
	uopPkg::regNumT nextReg;
	uopPkg::regCountT regsLeft;
	uopPkg::regCountT listCount;
	uopPkg::offsetT startOffset;
	logic addUp;

	uopClassifier i_uopClassifier (
		.instr(instr),
		.kind(kind)
	);

	regListTracker i_regListTracker (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.instr(instr),
		.state(state),
		.nextReg(nextReg),
		.regsLeft(regsLeft),
		.listCount(listCount),
		.startOffset(startOffset),
		.addUp(addUp)
	);

	uopStateMachine i_uopStateMachine (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.kind(kind),
		.regsLeft(regsLeft),
		.instr(instr),
		.state(state)
	);

	uopEncoder i_uopEncoder (
		.instr(instr),
		.state(state),
		.kind(kind),
		.nextReg(nextReg),
		.regsLeft(regsLeft),
		.listCount(listCount),
		.startOffset(startOffset),
		.addUp(addUp),
		.uopInstr(uopInstr),
		.ctrl(ctrl)
	);

endmodule

// ==== uopSequencer_props.sv ====
`timescale 1ns/1ps
`include "uopSequencer_defines.svh"

module uopSequencer_props (
	input logic clk,
	input logic reset,
	input logic [`INSTR_W-1:0] instr,
	input logic [`INSTR_W-1:0] uopInstr,
	input uopPkg::uopCtrlT ctrl
);

	// No micro-op means a clean pass-through
	passThroughRule: assert property (@(posedge clk) disable iff (reset)
		!ctrl.instrMux |-> (uopInstr == instr && ctrl == '0))
		else $error("pass-through micro-op differs from instruction");

	// Condition field always survives
	condRule: assert property (@(posedge clk) disable iff (reset)
		uopInstr[`COND_HI:`COND_LO] == instr[`COND_HI:`COND_LO])
		else $error("condition field changed");

	stallMuxRule: assert property (@(posedge clk) disable iff (reset)
		(ctrl.uopStall || ctrl.noFlagUpdate) |-> ctrl.instrMux)
		else $error("stall or flag suppression without micro-op");

	// Later list transfers read from Rz plus 4
	forwardRule: assert property (@(posedge clk) disable iff (reset)
		ctrl.listForward |-> (uopInstr[`RN_HI:`RN_LO] == `RZ_CODE
			&& uopInstr[11:0] == 12'd4 && uopInstr[`U_BIT]))
		else $error("list forward transfer not based on Rz plus 4");

	// Second RSR op ends the sequence with Rz unshifted
	rsrSecondRule: assert property (@(posedge clk) disable iff (reset)
		ctrl.prevRsr |-> (uopInstr[11:0] == {8'h00, `RZ_CODE} && !ctrl.uopStall))
		else $error("second RSR micro-op malformed");

endmodule

// ==== tb_uopSequencer.sv ====
`timescale 1ns/1ps
`include "uopSequencer_defines.svh"

module tb_uopSequencer;

	localparam logic [`INSTR_W-1:0] NOP = 32'hE1A00000; // MOV r0, r0

	logic clk;
	logic reset;
	logic stall;
	logic [`INSTR_W-1:0] instr;
	logic [`INSTR_W-1:0] uopInstr;
	uopPkg::uopCtrlT ctrl;
	logic [`INSTR_W-1:0] uops[$]; // Micro-ops of the last sequence
	uopPkg::uopCtrlT ctrls[$];

	uopSequencer i_uopSequencer (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.instr(instr),
		.uopInstr(uopInstr),
		.ctrl(ctrl)
	);

	bind uopSequencer uopSequencer_props i_uopSequencer_props (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.uopInstr(uopInstr),
		.ctrl(ctrl)
	);

	always #4 clk = ~clk; // 8 ns period

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic failCheck(input string name, input logic [31:0] got, input logic [31:0] exp);
		stopOnError($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// Start offset per P/U addressing mode
	function automatic logic [11:0] offsetFor(input logic p, input logic u, input int n);
		case ({p, u})
			2'b00: return 12'((n - 1) * 4); // Decrement after
			2'b01: return 12'd0; // Increment after
			2'b10: return 12'(n * 4); // Decrement before
			default: return 12'd4; // Increment before
		endcase
	endfunction

	// Check at mid-cycle, then move to the next drive point
	task automatic checkPass();
		#1;
		assert (uopInstr == instr) else failCheck("uopInstr", uopInstr, instr);
		assert (ctrl == '0) else failCheck("ctrl", 32'(ctrl), 32'h0);
		@(posedge clk);
		#1;
	endtask

	task automatic passThrough(input logic [`INSTR_W-1:0] ins);
		instr = ins;
		checkPass();
	endtask

	// Freeze for three edges, outputs must repeat
	task automatic holdStall();
		logic [`INSTR_W-1:0] heldInstr;
		uopPkg::uopCtrlT heldCtrl;
		stall = 1'b1;
		#1;
		heldInstr = uopInstr;
		heldCtrl = ctrl;
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			#1;
			assert (uopInstr == heldInstr) else failCheck("uopInstr", uopInstr, heldInstr);
			assert (ctrl == heldCtrl) else failCheck("ctrl", 32'(ctrl), 32'(heldCtrl));
		end
		stall = 1'b0;
	endtask

	// Collect micro-ops until uopStall falls
	task automatic runSequence(input logic [`INSTR_W-1:0] ins, input int stallAt);
		int cycles;
		instr = ins;
		uops.delete();
		ctrls.delete();
		cycles = 0;
		forever begin
			#1;
			uops.push_back(uopInstr);
			ctrls.push_back(ctrl);
			if (!ctrl.uopStall)
				break;
			cycles++;
			if (cycles > 40)
				stopOnError("Timeout: uopStall never cleared");
			@(posedge clk);
			#1;
			if (uops.size() == stallAt)
				holdStall(); // Stall in mid-sequence
		end
		@(posedge clk);
		#1;
		instr = NOP; // Decode moves on
	endtask

	task automatic checkRsr(input logic [`INSTR_W-1:0] ins);
		runSequence(ins, 0);
		assert (uops.size() == 2) else failCheck("RSR length", 32'(uops.size()), 32'd2);
		assert (uops[0] == {ins[31:28], 8'h1A, 4'h0, `RZ_CODE, ins[11:0]}) // MOV Rz, shifter
			else failCheck("uopInstr", uops[0], {ins[31:28], 8'h1A, 4'h0, `RZ_CODE, ins[11:0]});
		assert (ctrls[0].instrMux && ctrls[0].noFlagUpdate && ctrls[0].uopStall)
			else stopOnError("RSR first micro-op has wrong control bits");
		assert (ctrls[0].rzSelect[2]) // Rz on the write port
			else stopOnError("RSR first micro-op does not write Rz");
		assert (uops[1] == {ins[31:12], 8'h00, `RZ_CODE})
			else failCheck("uopInstr", uops[1], {ins[31:12], 8'h00, `RZ_CODE});
		assert (ctrls[1].prevRsr) else stopOnError("RSR second micro-op lacks prevRsr");
		assert (ctrls[1].rzSelect[1]) // Rz on read port 2
			else stopOnError("RSR second micro-op does not read Rz as its operand");
		checkPass();
	endtask

	task automatic checkBl(input logic [`INSTR_W-1:0] ins);
		runSequence(ins, 0);
		assert (uops.size() == 2) else failCheck("BL length", 32'(uops.size()), 32'd2);
		assert (uops[0] == {ins[31:28], 28'h24FE004}) // SUB r14, r15, #4
			else failCheck("uopInstr", uops[0], {ins[31:28], 28'h24FE004});
		assert (uops[1] == (ins & ~32'h0100_0000)) // Link bit cleared
			else failCheck("uopInstr", uops[1], ins & ~32'h0100_0000);
		checkPass();
	endtask

	task automatic checkList(input logic [`INSTR_W-1:0] ins, input int stallAt);
		int n;
		int k;
		logic wb;
		logic [3:0] rn;
		logic [`INSTR_W-1:0] expWb;
		n = $countones(ins[15:0]);
		wb = ins[`W_BIT];
		rn = ins[`RN_HI:`RN_LO];
		runSequence(ins, stallAt);
		assert (uops.size() == n + int'(wb))
			else failCheck("list length", 32'(uops.size()), 32'(n + int'(wb)));
		k = 0;
		for (int r = 0; r < `NUM_REGS; r++) begin
			if (ins[r]) begin
				assert (uops[k][15:12] == r[3:0]) else failCheck("Rd", 32'(uops[k][15:12]), 32'(r));
				assert (uops[k][`L_BIT] == ins[`L_BIT])
					else failCheck("L bit", 32'(uops[k][`L_BIT]), 32'(ins[`L_BIT]));
				if (k == 0) begin
					assert (uops[0][`RN_HI:`RN_LO] == rn)
						else failCheck("base", 32'(uops[0][19:16]), 32'(rn));
					assert (uops[0][11:0] == offsetFor(ins[`P_BIT], ins[`U_BIT], n))
						else failCheck("offset", 32'(uops[0][11:0]),
							32'(offsetFor(ins[`P_BIT], ins[`U_BIT], n)));
					assert (uops[0][`U_BIT] == ins[`U_BIT])
						else failCheck("U bit", 32'(uops[0][`U_BIT]), 32'(ins[`U_BIT]));
				end else begin
					assert (ctrls[k].listForward && ctrls[k].rzSelect[0]) // Base from Rz on port 1
						else stopOnError("later transfer not forwarded from Rz");
				end
				k++;
			end
		end
		expWb = {ins[31:28], 3'b001, ins[`U_BIT] ? 4'b0100 : 4'b0010, 1'b0, rn, rn, 4'hF, 8'(n)};
		if (wb)
			assert (uops[n] == expWb) else failCheck("writeback", uops[n], expWb);
	endtask

	initial begin
		logic [15:0] list;
		logic [`INSTR_W-1:0] ins;
		void'($urandom(4));
		clk = 1'b0;
		reset = 1'b1;
		stall = 1'b0;
		instr = NOP;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		passThrough(NOP);
		passThrough(32'hE0821103); // ADD with immediate shift
		passThrough(32'hE12FFF1E); // BX lr
		passThrough(32'hE0000291); // MUL
		passThrough(32'hE5901000); // LDR
		passThrough(32'hE8910000); // LDM with empty list
		checkRsr(32'hE0921413); // ADDS r1, r2, r3, LSL r4
		checkRsr(32'h10421356); // SUBNE r1, r2, r6, ASR r3
		checkBl(32'hEB000010);
		checkBl(32'h0BFFFFFE);
		checkList(32'hE8910004, 0); // One register, no writeback
		checkPass();
		checkList(32'hE8B10004, 0); // One register with writeback
		checkPass();
		for (int t = 0; t < 40; t++) begin
			list = 16'($urandom() & $urandom()); // Sparse lists
			if (list == '0)
				list = 16'h0001;
			ins = {4'hE, 3'b100, 1'($urandom()), 1'($urandom()), 1'b0, 1'($urandom()),
				1'($urandom()), 4'($urandom_range(0, 14)), list};
			checkList(ins, t % 3);
			checkPass();
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== uopSequencer.f ====
+incdir+.
uopPkg.sv
uopClassifier.sv
regListTracker.sv
uopStateMachine.sv
uopEncoder.sv
uopSequencer.sv
uopSequencer_props.sv
tb_uopSequencer.sv

// ==== Makefile ====
SIM := verilator
TOP := tb_uopSequencer
FILELIST := uopSequencer.f
SIMFLAGS := --binary --timing --assert -j 0
OBJDIR := obj_dir

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) uopSequencer_defines.svh
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
